// File: vlog.f
+incdir+common
common/apu_pkg.sv
common/wave_ctrl_if.sv
wave/wave_regs.sv
wave/wave_timer.sv
wave/wave_sampler.sv
source/sample_out.sv
source/apu_wave_top.sv
tb/tb_apu_wave.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_apu_wave -f vlog.f \
   > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_apu_wave > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "Simulation ended early"; exit 1; }
echo "Simulation PASSED"
exit 0

// File: tb/tb_apu_wave.sv
`timescale 1ns/1ps
`include "apu_config.svh"

module tb_apu_wave import apu_pkg::*;;

   localparam int T_REGS     = 150;
   localparam int T_SEQUENCE = 360;
   localparam int T_LEVELS   = 400;
   localparam int T_LENGTH   = 160;
   localparam int T_BACKPRES = 80;
   localparam int CYCLE_LIMIT = 4 * (10 + T_REGS + T_SEQUENCE + T_LEVELS + T_LENGTH
                                     + T_BACKPRES);
   localparam logic [10:0] FREQ_BASE = 11'd2040; // Eight ticks per position

   logic       I_BITCLK;
   logic       I_RESET;
   addr_t      reg_addr;
   logic [7:0] reg_wdata;
   logic       reg_we;
   logic       reg_re;
   logic [7:0] reg_rdata;
   logic       sample_tick;
   logic       out_valid;
   sample_t    out_sample;
   logic       out_ready;
   logic       out_overrun;

   logic [7:0]  reg_m [5];          // NR30 .. NR34
   logic [7:0]  wave_m [`WAVE_BYTES];
   sample_t     rx_q [$];           // Samples that left the DUT
   sample_t     exp_q [$];
   sample_t     prev_sample;
   logic [31:0] lcg_state = 32'h04e8ca42;
   string       test_name = "reset";
   int          errors = 0;
   int          tests_run = 0;
   int          tests_ok = 0;
   int          cycles = 0;

   apu_wave_top i_apu_wave_top (
      .I_BITCLK    (I_BITCLK),
      .I_RESET     (I_RESET),
      .reg_addr    (reg_addr),
      .reg_wdata   (reg_wdata),
      .reg_we      (reg_we),
      .reg_re      (reg_re),
      .reg_rdata   (reg_rdata),
      .sample_tick (sample_tick),
      .out_valid   (out_valid),
      .out_sample  (out_sample),
      .out_ready   (out_ready),
      .out_overrun (out_overrun)
   );

   initial begin
      I_BITCLK = 1'b0;
      forever #4 I_BITCLK = ~I_BITCLK;
   end

   always @(posedge I_BITCLK) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, test %s did not finish", cycles, test_name);
         $display("tests failed");
         $finish;
      end
   end

   // A transfer happens at the next rising edge
   always @(negedge I_BITCLK) begin
      if (!I_RESET && out_valid && out_ready) rx_q.push_back(out_sample);
   end

   always @(posedge I_BITCLK) prev_sample <= out_sample; // Value at the last falling edge

   a_stall_hold: assert property (@(negedge I_BITCLK) disable iff (I_RESET)
      (out_valid && !out_ready) |=> $stable(out_sample))
      else begin
         errors++;
         $display("Mismatch %s stalled sample: expected %h, actual %h",
                  test_name, prev_sample, out_sample);
      end

   a_overrun_sticky: assert property (@(negedge I_BITCLK) disable iff (I_RESET)
      out_overrun |=> out_overrun)
      else begin
         errors++;
         $display("%s: out_overrun went low without a reset", test_name);
      end

   function automatic logic [7:0] lcg_byte();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[23:16];
   endfunction

   function automatic logic [7:0] model_read(input addr_t addr);
      if (addr >= NR30_ADDR && addr <= NR34_ADDR) return reg_m[addr - NR30_ADDR];
      if (addr >= WAVE_BASE && addr < WAVE_BASE + `WAVE_BYTES) return wave_m[addr[3:0]];
      return 8'hFF;
   endfunction

   // High nibble first, level 0 mutes, level n shifts by n-1
   function automatic sample_t exp_amp(input int p, input logic [1:0] lvl, input logic dac);
      logic [7:0] b;
      logic [3:0] nib;
      logic [3:0] shifted;
      b = wave_m[p / 2];
      nib = (p % 2 == 1) ? b[3:0] : b[7:4];
      if (lvl == 2'd0) shifted = 4'd0;
      else shifted = nib >> (lvl - 2'd1);
      return dac ? level_amp(shifted) : '0;
   endfunction

   function automatic void expect_positions(input int n, input logic [1:0] lvl,
                                            input logic dac);
      for (int k = 0; k < n; k++) exp_q.push_back(exp_amp(k % `WAVE_SAMPLES, lvl, dac));
   endfunction

   task automatic bus_write(input addr_t addr, input logic [7:0] data);
      @(posedge I_BITCLK);
      reg_addr  <= addr;
      reg_wdata <= data;
      reg_we    <= 1'b1;
      @(posedge I_BITCLK);
      reg_we <= 1'b0;
      if (addr >= NR30_ADDR && addr <= NR34_ADDR) reg_m[addr - NR30_ADDR] = data;
      else if (addr >= WAVE_BASE && addr < WAVE_BASE + `WAVE_BYTES) wave_m[addr[3:0]] = data;
   endtask

   task automatic check_read(input addr_t addr);
      logic [7:0] exp;
      exp = model_read(addr);
      @(posedge I_BITCLK);
      reg_addr <= addr;
      reg_re   <= 1'b1;
      @(posedge I_BITCLK);
      reg_re <= 1'b0;
      @(negedge I_BITCLK);
      assert (reg_rdata == exp) else begin
         errors++;
         $display("Mismatch %s at %h: expected %h, actual %h", test_name, addr, exp, reg_rdata);
      end
   endtask

   task automatic restart_play(input logic cont, input logic [10:0] freq);
      bus_write(NR34_ADDR, {1'b1, cont, 3'b000, freq[10:8]});
      repeat (4) @(posedge I_BITCLK); // Samples from before the restart drain out
      rx_q.delete();
   endtask

   task automatic start_play(input logic dac, input logic [1:0] lvl, input logic [10:0] freq,
                             input logic cont, input logic [7:0] len);
      bus_write(NR30_ADDR, {dac, 7'd0});
      bus_write(NR31_ADDR, len);
      bus_write(NR32_ADDR, {1'b0, lvl, 5'd0});
      bus_write(NR33_ADDR, freq[7:0]);
      restart_play(cont, freq);
   endtask

   task automatic collect_check(input int n);
      sample_t got;
      while (rx_q.size() < n) @(negedge I_BITCLK);
      for (int k = 0; k < n; k++) begin
         got = rx_q[k];
         assert (got == exp_q[k]) else begin
            errors++;
            $display("Mismatch %s sample %0d: expected %h, actual %h",
                     test_name, k, exp_q[k], got);
         end
      end
      exp_q.delete();
   endtask

   task automatic play_check(input logic dac, input logic [1:0] lvl, input logic [10:0] freq,
                             input int n);
      start_play(dac, lvl, freq, 1'b1, 8'd0);
      expect_positions(n, lvl, dac);
      collect_check(n);
   endtask

   task automatic finish_test(input int err_before);
      tests_run++;
      if (errors == err_before) begin
         tests_ok++;
         $display("%s: ok", test_name);
      end else begin
         $display("%s: %0d errors", test_name, errors - err_before);
      end
   endtask

   initial begin
      int          err0;
      logic [7:0]  data;
      logic [10:0] freq;
      I_RESET     <= 1'b1;
      reg_addr    <= '0;
      reg_wdata   <= 8'd0;
      reg_we      <= 1'b0;
      reg_re      <= 1'b0;
      sample_tick <= 1'b0;
      out_ready   <= 1'b1;
      for (int i = 0; i < 5; i++) reg_m[i] = 8'd0;
      for (int i = 0; i < `WAVE_BYTES; i++) wave_m[i] = 8'd0;
      repeat (10) @(posedge I_BITCLK);
      I_RESET     <= 1'b0;
      sample_tick <= 1'b1; // One tick per clock keeps runs short

      test_name = "reg_readback";
      err0 = errors;
      @(negedge I_BITCLK);
      assert (!out_valid && !out_overrun && reg_rdata == 8'd0) else begin
         errors++;
         $display("%s: outputs not cleared by reset", test_name);
      end
      for (int a = 0; a < 5; a++) bus_write(addr_t'(NR30_ADDR + a), lcg_byte());
      for (int a = 0; a < `WAVE_BYTES; a++) bus_write(addr_t'(WAVE_BASE + a), lcg_byte());
      for (int a = 0; a < 5; a++) check_read(addr_t'(NR30_ADDR + a));
      for (int a = 0; a < `WAVE_BYTES; a++) check_read(addr_t'(WAVE_BASE + a));
      check_read(16'hFF1F);
      check_read(16'hFF40);
      check_read(16'h0000);
      finish_test(err0);

      test_name = "sample_sequence";
      err0 = errors;
      play_check(1'b1, 2'd1, FREQ_BASE, `WAVE_SAMPLES + 8); // Runs past the wrap
      finish_test(err0);

      test_name = "output_levels";
      err0 = errors;
      for (int l = 0; l < 4; l++) begin
         data = lcg_byte();
         freq = FREQ_BASE + {9'd0, data[1:0]};
         play_check(l != 1, 2'(l), freq, 8); // Slot 1 runs with the DAC off
      end
      finish_test(err0);

      test_name = "length_stop";
      err0 = errors;
      data = lcg_byte() | 8'h80;
      bus_write(WAVE_BASE, data);
      start_play(1'b1, 2'd1, FREQ_BASE, 1'b0, 8'd254);
      repeat (4 * `LEN_STEP_TICKS) @(posedge I_BITCLK);
      rx_q.delete();
      for (int k = 0; k < 3; k++) exp_q.push_back('0);
      collect_check(3);
      restart_play(1'b0, FREQ_BASE);
      expect_positions(1, 2'd1, 1'b1);
      collect_check(1);
      finish_test(err0);

      test_name = "back_pressure";
      err0 = errors;
      start_play(1'b1, 2'd1, FREQ_BASE, 1'b1, 8'd0);
      out_ready <= 1'b0;
      while (!out_valid) @(negedge I_BITCLK);
      repeat (2048 - FREQ_BASE) @(negedge I_BITCLK); // Second sample now queued
      assert (!out_overrun) else begin
         errors++;
         $display("%s: out_overrun set before the buffer filled", test_name);
      end
      while (!out_overrun) @(negedge I_BITCLK);
      assert (out_valid) else begin
         errors++;
         $display("%s: out_valid low with a full buffer", test_name);
      end
      expect_positions(2, 2'd1, 1'b1);
      @(posedge I_BITCLK);
      out_ready <= 1'b1;
      collect_check(2);
      finish_test(err0);

      $display("%0d of %0d tests ok, %0d errors", tests_ok, tests_run, errors);
      if (errors == 0) $display("all tests passed");
      else $display("tests failed");
      $finish;
   end

endmodule

// File: source/apu_wave_top.sv
`timescale 1ns/1ps

module apu_wave_top import apu_pkg::*; (
   input  logic        I_BITCLK,
   input  logic        I_RESET,

   // CPU register bus
   input  addr_t       reg_addr,
   input  logic [7:0]  reg_wdata,
   input  logic        reg_we,
   input  logic        reg_re,
   output logic [7:0]  reg_rdata,

   input  logic        sample_tick,

   // Sample output
   output logic        out_valid,
   output sample_t     out_sample,
   input  logic        out_ready,
   output logic        out_overrun
);

   logic [3:0] wave_idx;
   logic [7:0] wave_byte;
   logic       step;
   logic [4:0] pos;
   logic       playing;

   wave_ctrl_if ctrl_if ();
   wave_stream  stream_if ();

   wave_regs i_wave_regs (
      .I_BITCLK  (I_BITCLK),
      .I_RESET   (I_RESET),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_we    (reg_we),
      .reg_re    (reg_re),
      .reg_rdata (reg_rdata),
      .wave_idx  (wave_idx),
      .wave_byte (wave_byte),
      .ctrl      (ctrl_if.regs)
   );

   wave_timer i_wave_timer (
      .I_BITCLK    (I_BITCLK),
      .I_RESET     (I_RESET),
      .sample_tick (sample_tick),
      .ctrl        (ctrl_if.sink),
      .step        (step),
      .pos         (pos),
      .playing     (playing)
   );

   wave_sampler i_wave_sampler (
      .I_BITCLK  (I_BITCLK),
      .I_RESET   (I_RESET),
      .step      (step),
      .pos       (pos),
      .playing   (playing),
      .wave_byte (wave_byte),
      .wave_idx  (wave_idx),
      .ctrl      (ctrl_if.sink),
      .src       (stream_if.src)
   );

   sample_out i_sample_out (
      .I_BITCLK    (I_BITCLK),
      .I_RESET     (I_RESET),
      .snk         (stream_if.snk),
      .out_valid   (out_valid),
      .out_sample  (out_sample),
      .out_ready   (out_ready),
      .out_overrun (out_overrun)
   );

endmodule

// File: source/sample_out.sv
`timescale 1ns/1ps

module sample_out import apu_pkg::*; (
   input  logic     I_BITCLK,
   input  logic     I_RESET,
   wave_stream.snk  snk,
   output logic     out_valid,
   output sample_t  out_sample,
   input  logic     out_ready,
   output logic     out_overrun
);

   sample_t    mem [2];
   logic       wr_ptr;
   logic       rd_ptr;
   logic [1:0] count;
   logic       push;
   logic       pop;
   logic       overrun_q;

   assign snk.ready = (count != 2'd2);
   assign push      = snk.valid && snk.ready;
   assign pop       = out_valid && out_ready;

   assign out_valid  = (count != 2'd0);
   assign out_sample = mem[rd_ptr];

   always_ff @(posedge I_BITCLK) begin
      if (I_RESET) begin
         mem[0]    <= '0;
         mem[1]    <= '0;
         wr_ptr    <= 1'b0;
         rd_ptr    <= 1'b0;
         count     <= 2'd0;
         overrun_q <= 1'b0;
      end else begin
         if (push) begin
            mem[wr_ptr] <= snk.data;
            wr_ptr      <= ~wr_ptr;
         end
         if (pop) rd_ptr <= ~rd_ptr;
         case ({push, pop})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: count <= count;
         endcase
         if (snk.valid && !snk.ready) overrun_q <= 1'b1; // Sticky until reset
      end
   end

   assign snk.overrun = overrun_q;
   assign out_overrun = overrun_q;

   a_hold_when_stalled: assert property (@(posedge I_BITCLK) disable iff (I_RESET)
      (out_valid && !out_ready) |=> $stable(out_sample));

endmodule

// File: wave/wave_sampler.sv
`timescale 1ns/1ps

module wave_sampler import apu_pkg::*; (
   input  logic        I_BITCLK,
   input  logic        I_RESET,
   input  logic        step,
   input  logic [4:0]  pos,
   input  logic        playing,
   input  logic [7:0]  wave_byte,
   output logic [3:0]  wave_idx,
   wave_ctrl_if.sink   ctrl,
   wave_stream.src     src
);

   logic [3:0] nibble;
   logic [3:0] scaled;
   sample_t    amp;
   logic       s_valid;
   sample_t    s_data;

   assign wave_idx = pos[4:1];

   // High nibble plays first
   assign nibble = pos[0] ? wave_byte[3:0] : wave_byte[7:4];
   assign scaled = level_shift(nibble, ctrl.level_sel);
   assign amp    = (ctrl.dac_on && playing) ? level_amp(scaled) : '0;

   always_ff @(posedge I_BITCLK) begin
      if (I_RESET) begin
         s_valid <= 1'b0;
         s_data  <= '0;
      end else begin
         s_valid <= step;
         if (step) s_data <= amp; // Pos before the timer increments it
      end
   end

   assign src.valid = s_valid;
   assign src.data  = s_data;

endmodule

// File: wave/wave_timer.sv
`timescale 1ns/1ps
`include "apu_config.svh"

module wave_timer (
   input  logic        I_BITCLK,
   input  logic        I_RESET,
   input  logic        sample_tick,
   wave_ctrl_if.sink   ctrl,
   output logic        step,
   output logic [4:0]  pos,
   output logic        playing
);

   localparam int DIV_W = $clog2(`LEN_STEP_TICKS);

   logic [11:0]      period_cnt;  // Zero until the first restart
   logic [11:0]      period_load;
   logic [DIV_W-1:0] len_div;
   logic [8:0]       len_cnt;
   logic [8:0]       len_limit;
   logic             len_tick;

   assign period_load = 12'd2048 - {1'b0, ctrl.freq};
   assign len_limit   = 9'd256 - {1'b0, ctrl.length_load};

   assign step     = sample_tick && (period_cnt == 12'd1);
   assign len_tick = sample_tick && playing
                     && (len_div == DIV_W'(`LEN_STEP_TICKS - 1));

   always_ff @(posedge I_BITCLK) begin
      if (I_RESET) begin
         period_cnt <= 12'd0;
         pos        <= 5'd0;
         playing    <= 1'b0;
         len_div    <= '0;
         len_cnt    <= 9'd0;
      end else if (ctrl.restart) begin
         period_cnt <= period_load;
         pos        <= 5'd0;
         playing    <= 1'b1;
         len_div    <= '0;
         len_cnt    <= 9'd0;
      end else begin
         if (step) begin
            period_cnt <= period_load;
            pos <= (pos == 5'(`WAVE_SAMPLES - 1)) ? 5'd0 : pos + 5'd1;
         end else if (sample_tick && (period_cnt != 12'd0)) begin
            period_cnt <= period_cnt - 12'd1;
         end

         if (sample_tick && playing) begin
            len_div <= len_tick ? '0 : len_div + 1'b1;
         end
         if (len_tick && (len_cnt < len_limit)) len_cnt <= len_cnt + 9'd1; // Saturates at limit

         // Length expiry, ignored in continuous mode
         if (!ctrl.continuous && (len_cnt >= len_limit)) playing <= 1'b0;
      end
   end

   a_pos_moves_on_step: assert property (@(posedge I_BITCLK) disable iff (I_RESET)
      !(step || ctrl.restart) |=> $stable(pos));

endmodule

// File: wave/wave_regs.sv
`timescale 1ns/1ps
`include "apu_config.svh"

module wave_regs import apu_pkg::*; (
   input  logic        I_BITCLK,
   input  logic        I_RESET,
   input  addr_t       reg_addr,
   input  logic [7:0]  reg_wdata,
   input  logic        reg_we,
   input  logic        reg_re,
   output logic [7:0]  reg_rdata,
   input  logic [3:0]  wave_idx,
   output logic [7:0]  wave_byte,
   wave_ctrl_if.regs   ctrl
);

   logic [7:0] nr30;
   logic [7:0] nr31;
   logic [7:0] nr32;
   logic [7:0] nr33;
   logic [7:0] nr34;
   logic [7:0] wave_ram [`WAVE_BYTES];
   logic       in_wave;
   logic [7:0] rd_val;
   logic       restart_q;

   assign in_wave = (reg_addr >= WAVE_BASE) && (reg_addr < WAVE_BASE + `WAVE_BYTES);

   // CPU writes
   always_ff @(posedge I_BITCLK) begin
      if (I_RESET) begin
         nr30 <= 8'd0;
         nr31 <= 8'd0;
         nr32 <= 8'd0;
         nr33 <= 8'd0;
         nr34 <= 8'd0;
         for (int i = 0; i < `WAVE_BYTES; i++) begin
            wave_ram[i] <= 8'd0;
         end
      end else if (reg_we) begin
         case (reg_addr)
            NR30_ADDR: nr30 <= reg_wdata;
            NR31_ADDR: nr31 <= reg_wdata;
            NR32_ADDR: nr32 <= reg_wdata;
            NR33_ADDR: nr33 <= reg_wdata;
            NR34_ADDR: nr34 <= reg_wdata;
            default: begin
               if (in_wave) wave_ram[reg_addr[3:0]] <= reg_wdata;
            end
         endcase
      end
   end

   // Read mux, unmapped addresses float high
   always_comb begin
      case (reg_addr)
         NR30_ADDR: rd_val = nr30;
         NR31_ADDR: rd_val = nr31;
         NR32_ADDR: rd_val = nr32;
         NR33_ADDR: rd_val = nr33;
         NR34_ADDR: rd_val = nr34;
         default:   rd_val = in_wave ? wave_ram[reg_addr[3:0]] : 8'hFF;
      endcase
   end

   always_ff @(posedge I_BITCLK) begin
      if (I_RESET) begin
         reg_rdata <= 8'd0;
         restart_q <= 1'b0;
      end else begin
         if (reg_re) reg_rdata <= rd_val; // Data valid the cycle after reg_re
         restart_q <= reg_we && (reg_addr == NR34_ADDR) && reg_wdata[7];
      end
   end

   assign wave_byte = wave_ram[wave_idx]; // Sampler read port

   assign ctrl.dac_on      = nr30[7];
   assign ctrl.length_load = nr31;
   assign ctrl.level_sel   = nr32[6:5];
   assign ctrl.freq        = {nr34[2:0], nr33};
   assign ctrl.continuous  = nr34[6];
   assign ctrl.restart     = restart_q;

   a_restart_single: assert property (@(posedge I_BITCLK) disable iff (I_RESET)
      restart_q |=> !restart_q);

endmodule

// File: common/wave_ctrl_if.sv
`timescale 1ns/1ps

// Decoded channel controls from the register block
interface wave_ctrl_if;
   logic        dac_on;      // NR30 bit 7
   logic [7:0]  length_load; // NR31
   logic [1:0]  level_sel;   // NR32 bits 6:5
   logic [10:0] freq;        // NR34[2:0] with NR33
   logic        continuous;  // NR34 bit 6
   logic        restart;     // One cycle pulse

   modport regs (output dac_on, length_load, level_sel, freq, continuous, restart);
   modport sink (input dac_on, length_load, level_sel, freq, continuous, restart);
endinterface

// Sample stream from the sampler into the output buffer
interface wave_stream import apu_pkg::*;;
   logic    valid;
   sample_t data;
   logic    ready;
   logic    overrun; // Sticky drop flag from the buffer

   modport src (output valid, data, input ready, overrun);
   modport snk (input valid, data, output ready, overrun);
endinterface

// File: common/apu_pkg.sv
package apu_pkg;

   typedef logic [15:0] addr_t;   // CPU bus address
   typedef logic [19:0] sample_t; // Unsigned output amplitude

   // Channel 3 register map
   localparam addr_t NR30_ADDR = 16'hFF1A; // DAC enable
   localparam addr_t NR31_ADDR = 16'hFF1B; // Sound length
   localparam addr_t NR32_ADDR = 16'hFF1C; // Output level
   localparam addr_t NR33_ADDR = 16'hFF1D; // Frequency low byte
   localparam addr_t NR34_ADDR = 16'hFF1E; // Restart, continuous, frequency high bits
   localparam addr_t WAVE_BASE = 16'hFF30; // First byte of wave RAM

   localparam sample_t AMP_FULL = 20'h7FFFF; // Amplitude for a nibble of 15

   // Scales a 4-bit level linearly onto 0 .. AMP_FULL, rounding down
   function automatic sample_t level_amp(input logic [3:0] n);
      logic [23:0] prod;
      prod = n * {4'd0, AMP_FULL};
      return sample_t'(prod / 24'd15);
   endfunction

   // Output level select applied to one wave nibble
   function automatic logic [3:0] level_shift(input logic [3:0] nib,
                                              input logic [1:0] sel);
      logic [3:0] res;
      case (sel)
         2'd0:    res = 4'd0;      // Mute
         2'd1:    res = nib;       // 100%
         2'd2:    res = nib >> 1;  // 50%
         default: res = nib >> 2;  // 25%
      endcase
      return res;
   endfunction

endpackage

// File: common/apu_config.svh
`ifndef APU_CONFIG_SVH
`define APU_CONFIG_SVH

// Wave RAM holds two 4-bit samples per byte
`define WAVE_BYTES 16
`define WAVE_SAMPLES 32

// Sample ticks per length counter step
`define LEN_STEP_TICKS 8

`endif
